// File: rtl/core_pkg.sv
/*
 shared widths and enums for the RV64I integer ALU core
 alu_op_t values equal func3 so a func3 field casts straight to it
 insn_class_t is one-hot; any opcode not listed here is treated as invalid
*/
package core_pkg;

    localparam int xlen = 64; // data and register width

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_exec_r,    // register-register forms
        st_exec_i,    // immediate forms and auipc
        st_writeback,
        st_halt
    } state_t;

    typedef enum logic [2:0] {
        op_add  = 3'b000, // also sub with sub_sra
        op_sll  = 3'b001,
        op_slt  = 3'b010,
        op_sltu = 3'b011,
        op_xor  = 3'b100,
        op_srl  = 3'b101, // also sra with sub_sra
        op_or   = 3'b110,
        op_and  = 3'b111
    } alu_op_t;

    typedef enum logic [6:0] {
        opc_op       = 7'b0110011,
        opc_op_imm   = 7'b0010011,
        opc_op32     = 7'b0111011,
        opc_op_imm32 = 7'b0011011,
        opc_auipc    = 7'b0010111
    } opcode_t;

    typedef enum logic [5:0] {
        cls_op       = 6'b000001,
        cls_op_imm   = 6'b000010,
        cls_op32     = 6'b000100,
        cls_op_imm32 = 6'b001000,
        cls_auipc    = 6'b010000,
        cls_invalid  = 6'b100000
    } insn_class_t;

endpackage

// File: rtl/opdecoder.sv
/*
 opcode decoder, purely combinational
 only bits 6:0 are looked at; func3/func7 legality is not checked
*/
`timescale 1ns/1ns

module opdecoder (
    input  logic [31:0]               insn,
    output core_pkg::insn_class_t     insn_class
);

    always_comb begin
        case (insn[6:0])
            core_pkg::opc_op:       insn_class = core_pkg::cls_op;
            core_pkg::opc_op_imm:   insn_class = core_pkg::cls_op_imm;
            core_pkg::opc_op32:     insn_class = core_pkg::cls_op32;
            core_pkg::opc_op_imm32: insn_class = core_pkg::cls_op_imm32;
            core_pkg::opc_auipc:    insn_class = core_pkg::cls_auipc;
            default:                insn_class = core_pkg::cls_invalid; // halts the core
        endcase
    end

endmodule

// File: rtl/fsm_alu.sv
/*
 multicycle control FSM: fetch, decode, execute, writeback
 all outputs are registered from the next state, so they line up with the state
 run_start is only honoured in idle or halt
*/
`timescale 1ns/1ns

module fsm_alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run_start,
    input  logic [31:0]           insn,
    input  core_pkg::insn_class_t insn_class,
    output logic                  load_pc,
    output logic                  load_ins,
    output logic                  load_rs1,
    output logic                  load_rs2,
    output logic                  load_imm,
    output logic                  load_alu,
    output logic                  load_regfile,
    output logic                  sel_alu_a,     // 1 = pc
    output logic                  sel_alu_b,     // 1 = immediate
    output logic                  sub_sra,
    output logic                  word_op,
    output core_pkg::alu_op_t     alu_op,
    output logic                  busy,
    output logic                  halted
);

    core_pkg::state_t state;
    core_pkg::state_t next;
    logic [2:0]       func3;
    logic             set_less;

    assign func3    = insn[14:12];
    assign set_less = (func3 == 3'b010) || (func3 == 3'b011); // compare runs as a subtract

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= core_pkg::st_idle;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            core_pkg::st_idle,
            core_pkg::st_halt:      if (run_start) next = core_pkg::st_fetch;
            core_pkg::st_fetch:     next = core_pkg::st_decode;
            core_pkg::st_decode: begin
                case (insn_class)
                    core_pkg::cls_op,
                    core_pkg::cls_op32:     next = core_pkg::st_exec_r;
                    core_pkg::cls_op_imm,
                    core_pkg::cls_op_imm32,
                    core_pkg::cls_auipc:    next = core_pkg::st_exec_i;
                    default:                next = core_pkg::st_halt;
                endcase
            end
            core_pkg::st_exec_r,
            core_pkg::st_exec_i:    next = core_pkg::st_writeback;
            core_pkg::st_writeback: next = core_pkg::st_fetch; // pc already moved on
            default:                next = core_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {load_pc, load_ins, load_rs1, load_rs2, load_imm, load_alu} <= '0;
            {load_regfile, sel_alu_a, sel_alu_b, sub_sra, word_op} <= '0;
            alu_op <= core_pkg::op_add;
            busy   <= 1'b0;
            halted <= 1'b0;
        end else begin
            {load_pc, load_ins, load_rs1, load_rs2, load_imm, load_alu} <= '0;
            {load_regfile, sel_alu_a, sel_alu_b, sub_sra, word_op} <= '0;
            alu_op <= core_pkg::op_add;
            busy   <= (next != core_pkg::st_idle) && (next != core_pkg::st_halt);
            halted <= next == core_pkg::st_halt;
            case (next)
                core_pkg::st_fetch:  load_ins <= 1'b1;
                core_pkg::st_decode: begin
                    load_rs1 <= 1'b1;
                    load_rs2 <= 1'b1;
                    load_imm <= 1'b1;
                end
                core_pkg::st_exec_r: begin
                    load_alu <= 1'b1;
                    alu_op   <= core_pkg::alu_op_t'(func3);
                    sub_sra  <= set_less || insn[30]; // bit 30 marks sub and sra
                    word_op  <= insn_class == core_pkg::cls_op32;
                end
                core_pkg::st_exec_i: begin
                    load_alu  <= 1'b1;
                    sel_alu_b <= 1'b1;
                    if (insn_class == core_pkg::cls_auipc) begin
                        sel_alu_a <= 1'b1; // pc + U immediate, plain add
                    end else begin
                        alu_op  <= core_pkg::alu_op_t'(func3);
                        sub_sra <= set_less || (func3 == 3'b101 && insn[30]); // srai
                        word_op <= insn_class == core_pkg::cls_op_imm32;
                    end
                end
                core_pkg::st_writeback: begin
                    load_pc      <= 1'b1;
                    load_regfile <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // each step owns one group of loads
    loads_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({load_ins, load_rs1 | load_rs2 | load_imm, load_alu, load_pc | load_regfile}));

    // a register write always follows the execute step that loaded the result
    rf_write_in_wb: assert property (@(posedge clk) disable iff (!rst_n)
        load_regfile |-> state == core_pkg::st_writeback && $past(load_alu));

endmodule

// File: rtl/alu.sv
/*
 64-bit integer ALU, combinational
 flags always come from the full 64-bit a - b
 word_op works on the low 32 bits and sign-extends the result
*/
`timescale 1ns/1ns

module alu (
    input  logic [core_pkg::xlen-1:0] a,
    input  logic [core_pkg::xlen-1:0] b,
    input  core_pkg::alu_op_t         alu_op,
    input  logic                      sub_sra,
    input  logic                      word_op,
    output logic [core_pkg::xlen-1:0] result,
    output logic                      lu,
    output logic                      ls,
    output logic                      eq
);

    localparam int w = core_pkg::xlen;

    logic [w:0]   diff;     // carry out in the top bit
    logic [w-1:0] sum;
    logic [w-1:0] shr_src;
    logic [w-1:0] sra_res;
    logic [w-1:0] raw;
    logic [5:0]   shamt;

    assign diff  = {1'b0, a} + {1'b0, ~b} + 1'b1;
    assign sum   = sub_sra ? diff[w-1:0] : a + b;
    assign lu    = ~diff[w];                                      // borrow
    assign ls    = (a[w-1] ^ b[w-1]) ? a[w-1] : diff[w-1];
    assign eq    = diff[w-1:0] == '0;
    assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];

    // right shifts in word mode start from a 32-bit value
    assign shr_src = !word_op ? a :
                     sub_sra  ? {{(w-32){a[31]}}, a[31:0]} : {{(w-32){1'b0}}, a[31:0]};
    assign sra_res = $signed(shr_src) >>> shamt;

    always_comb begin
        case (alu_op)
            core_pkg::op_add:  raw = sum;
            core_pkg::op_sll:  raw = a << shamt;
            core_pkg::op_slt:  raw = {{(w-1){1'b0}}, ls};
            core_pkg::op_sltu: raw = {{(w-1){1'b0}}, lu};
            core_pkg::op_xor:  raw = a ^ b;
            core_pkg::op_srl:  raw = sub_sra ? sra_res : shr_src >> shamt;
            core_pkg::op_or:   raw = a | b;
            core_pkg::op_and:  raw = a & b;
            default:           raw = sum;
        endcase
    end

    assign result = word_op ? {{(w-32){raw[31]}}, raw[31:0]} : raw;

    // a - b is zero exactly when the operands match
    eq_tracks_sub: assert final (eq == (a == b));

endmodule

// File: rtl/regfile.sv
/*
 32 x 64-bit register file, two async read ports and one write port
 x0 is never written, so it reads as zero after reset
 host port reads the current value, even mid-run
*/
`timescale 1ns/1ns

module regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    input  logic [4:0]                rd_addr,
    input  logic [core_pkg::xlen-1:0] rd_data,
    input  logic                      we,
    output logic [core_pkg::xlen-1:0] rs1_data,
    output logic [core_pkg::xlen-1:0] rs2_data,
    input  logic [4:0]                host_reg_addr,
    output logic [core_pkg::xlen-1:0] host_reg_data
);

    logic [core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data      = regs[rs1_addr];
    assign rs2_data      = regs[rs2_addr];
    assign host_reg_data = regs[host_reg_addr];

endmodule

// File: rtl/datapath.sv
/*
 pc, instruction, operand, immediate and ALU result registers around the regfile and ALU
 pc is 32 bits, zero-extended for auipc, and does not wrap
 imem_words bounds the fetch address
*/
`timescale 1ns/1ns

module datapath #(
    parameter int imem_words = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run_start,
    input  logic [31:0]               imem_rdata,
    output logic [31:0]               pc,
    output logic [31:0]               insn,
    input  logic                      load_pc,
    input  logic                      load_ins,
    input  logic                      load_rs1,
    input  logic                      load_rs2,
    input  logic                      load_imm,
    input  logic                      load_alu,
    input  logic                      load_regfile,
    input  logic                      sel_alu_a,
    input  logic                      sel_alu_b,
    input  logic                      sub_sra,
    input  logic                      word_op,
    input  core_pkg::alu_op_t         alu_op,
    input  logic [4:0]                host_reg_addr,
    output logic [core_pkg::xlen-1:0] host_reg_data
);

    localparam int w = core_pkg::xlen;

    logic [w-1:0] rs1_data, rs2_data;
    logic [w-1:0] rs1_q, rs2_q, imm_q, alu_q;
    logic [w-1:0] imm, alu_a, alu_b, alu_y;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run_start) begin
            pc <= '0;
        end else if (load_pc) begin
            pc <= pc + 32'd4; // same edge as the register write
        end
    end

    always_ff @(posedge clk) begin
        if (load_ins) insn  <= imem_rdata;
        if (load_rs1) rs1_q <= rs1_data;
        if (load_rs2) rs2_q <= rs2_data;
        if (load_imm) imm_q <= imm;
        if (load_alu) alu_q <= alu_y;
    end

    // U immediate for auipc, I immediate otherwise
    assign imm = (insn[6:0] == core_pkg::opc_auipc) ? {{(w-32){insn[31]}}, insn[31:12], 12'b0}
                                                     : {{(w-12){insn[31]}}, insn[31:20]};

    assign alu_a = sel_alu_a ? {{(w-32){1'b0}}, pc} : rs1_q;
    assign alu_b = sel_alu_b ? imm_q : rs2_q;

    regfile u_regfile (
        .clk, .rst_n,
        .rs1_addr(insn[19:15]), .rs2_addr(insn[24:20]), .rd_addr(insn[11:7]),
        .rd_data(alu_q), .we(load_regfile),
        .rs1_data, .rs2_data,
        .host_reg_addr, .host_reg_data
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .alu_op, .sub_sra, .word_op,
        .result(alu_y), .lu(), .ls(), .eq()
    );

    // a program must halt before running off the end of the memory
    fetch_in_imem: assert property (@(posedge clk) disable iff (!rst_n)
        load_ins |-> pc < imem_words * 4);

endmodule

// File: rtl/apb_host_port.sv
/*
 APB slave: instruction memory, run control, status and register readback
 zero wait states; imem_words must not exceed 64 or it overlaps the control words
 a run_start request while busy is dropped
*/
`timescale 1ns/1ns

module apb_host_port #(
    parameter int imem_words = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [11:0]               paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic [31:0]               pc,
    output logic [31:0]               imem_rdata,
    output logic                      run_start,
    output logic [4:0]                host_reg_addr,
    input  logic [core_pkg::xlen-1:0] host_reg_data,
    input  logic                      busy,
    input  logic                      halted
);

    localparam int aw = $clog2(imem_words);

    logic [31:0] imem [imem_words];
    logic        access, wr;
    logic        in_imem, in_ctrl, in_status, in_regs, mapped;

    assign access    = psel && penable;          // access phase
    assign wr        = access && pwrite;
    assign in_imem   = paddr < imem_words * 4;
    assign in_ctrl   = paddr == 12'h100;
    assign in_status = paddr == 12'h104;
    assign in_regs   = paddr[11:8] == 4'h2;      // 0x200..0x2fc
    assign mapped    = in_imem || in_ctrl || in_status || in_regs;

    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && (in_status || in_regs || (in_imem && busy))));

    always_ff @(posedge clk) begin
        if (wr && in_imem && !busy) imem[paddr[aw+1:2]] <= pwdata;
    end

    assign imem_rdata    = imem[pc[aw+1:2]]; // fetch port
    assign host_reg_addr = paddr[7:3];

    always_comb begin
        prdata = '0;
        if (in_imem) prdata = imem[paddr[aw+1:2]];
        else if (in_status) prdata = {30'b0, halted, busy};
        else if (in_regs) prdata = paddr[2] ? host_reg_data[63:32] : host_reg_data[31:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_start <= 1'b0;
        end else begin
            run_start <= wr && in_ctrl && pwdata[0] && !busy; // one-cycle pulse
        end
    end

    start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        run_start |=> !run_start);

endmodule

// File: rtl/alu_core_top.sv
/*
 top level of the RV64I ALU core, host access through one APB slave port
 imem_words sets the instruction memory depth, 64 at most
*/
`timescale 1ns/1ns

module alu_core_top #(
    parameter int imem_words = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [31:0]               pc, insn, imem_rdata;
    logic                      run_start, busy, halted;
    logic [4:0]                host_reg_addr;
    logic [core_pkg::xlen-1:0] host_reg_data;
    core_pkg::insn_class_t     insn_class;
    core_pkg::alu_op_t         alu_op;
    logic                      load_pc, load_ins, load_rs1, load_rs2, load_imm;
    logic                      load_alu, load_regfile;
    logic                      sel_alu_a, sel_alu_b, sub_sra, word_op;

    apb_host_port #(.imem_words(imem_words)) u_apb (.*);

    opdecoder u_dec (.*);

    fsm_alu u_fsm (.*);

    datapath #(.imem_words(imem_words)) u_dp (.*);

endmodule

// File: testbench/tb_alu_core.sv
/*
 testbench for the RV64I ALU core, host side over APB only
 programs are built here and checked against a register model kept in step with them
 registers are not cleared between runs, so the model carries over too
 the busy-write check reruns the second program, whose sources are only x1 and x2
*/
`timescale 1ns/1ns

module tb_alu_core;

    localparam int period    = 10;
    localparam int max_insns = 3 * 63;                // three runs of at most 63 instructions
    localparam int max_xfers = 3 * (64 + 64 + 4) + 8; // loads, readbacks, control, error probes

    logic        clk;
    logic        rst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [63:0] model_regs [32];   // expected register file
    logic [31:0] prog [$];          // program being built
    logic [63:0] rng_state;
    int          rd_count;
    logic        chk_rdata;         // compare prdata in this access
    logic [31:0] exp_rdata;
    logic        exp_err;           // expected pslverr, 0 unless probing an error

    int unsigned r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7}; // add sub sll slt sltu xor srl sra or and
    int unsigned i_f3 [6]  = '{0, 2, 3, 4, 6, 7};             // addi slti sltiu xori ori andi

    alu_core_top #(.imem_words(64)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        stop_run();
    endtask

    // checks sample just before the edge that completes the access
    rdata_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && chk_rdata) |-> prdata == exp_rdata)
        else report_mismatch("prdata", $sampled(prdata), $sampled(exp_rdata));

    err_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pslverr == exp_err)
        else report_mismatch("pslverr", $sampled(pslverr), $sampled(exp_err));

    ready_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pready)
        else begin
            $display("pready was low in an access phase at %0t", $time);
            stop_run();
        end

    initial begin
        #(2 * (4 * max_insns + 3 * max_xfers + 8) * period);
        $display("timeout: the run did not finish within the time allowed");
        stop_run();
    end

    function automatic logic [63:0] rand64();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    function automatic logic [4:0] next_rd();
        next_rd = 5'(3 + rd_count % 29); // never x1 or x2, the operand sources
        rd_count++;
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // ISA-level result of one instruction, written into the model
    function automatic void model_exec(input logic [31:0] ins, input logic [31:0] at_pc);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        is_r;
        logic        is_w;
        logic        alt;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] r;
        logic [31:0] w;
        opc  = ins[6:0];
        f3   = ins[14:12];
        is_r = opc == 7'h33 || opc == 7'h3b;
        is_w = opc == 7'h3b || opc == 7'h1b;
        alt  = ins[30];
        x    = model_regs[ins[19:15]];
        y    = is_r ? model_regs[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
        w    = '0;
        r    = '0;
        if (opc == 7'h17) begin
            r = {32'b0, at_pc} + {{32{ins[31]}}, ins[31:12], 12'b0}; // auipc
        end else if (is_w) begin
            case (f3)
                3'd0: w = (alt && is_r) ? x[31:0] - y[31:0] : x[31:0] + y[31:0];
                3'd1: w = x[31:0] << y[4:0];
                3'd5: begin
                    if (alt) w = $signed(x[31:0]) >>> y[4:0];
                    else w = x[31:0] >> y[4:0];
                end
                default: w = '0;
            endcase
            r = {{32{w[31]}}, w}; // word results sign-extend from bit 31
        end else begin
            case (f3)
                3'd0: r = (alt && is_r) ? x - y : x + y;
                3'd1: r = x << y[5:0];
                3'd2: r = {63'b0, $signed(x) < $signed(y)};
                3'd3: r = {63'b0, x < y};
                3'd4: r = x ^ y;
                3'd5: begin
                    if (alt) r = $signed(x) >>> y[5:0];
                    else r = x >> y[5:0];
                end
                3'd6: r = x | y;
                default: r = x & y;
            endcase
        end
        if (ins[11:7] != 5'd0) model_regs[ins[11:7]] = r; // x0 stays zero
    endfunction

    task automatic emit(input logic [31:0] ins);
        model_exec(ins, 32'(4 * prog.size()));
        prog.push_back(ins);
    endtask

    // 66 random bits squeezed into rd, 11 at a time
    task automatic build_value(input logic [4:0] rd);
        logic [63:0] r;
        r = rand64();
        emit(itype({1'b0, r[10:0]}, 5'd0, 3'b000, rd, 7'h13)); // addi
        repeat (5) begin
            r = rand64();
            emit(itype(12'd11, rd, 3'b001, rd, 7'h13));        // slli 11
            emit(itype({1'b0, r[10:0]}, rd, 3'b110, rd, 7'h13)); // ori
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        @(negedge clk);
        psel    = 1'b1; // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1; // access phase
        #1 rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] unused;
        exp_rdata = exp;
        chk_rdata = 1'b1;
        apb_xfer(1'b0, addr, 32'h0, unused);
        chk_rdata = 1'b0;
    endtask

    task automatic expect_err(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        exp_err = 1'b1;
        apb_xfer(wr, addr, wdata, unused);
        exp_err = 1'b0;
    endtask

    task automatic load_program();
        logic [31:0] unused;
        foreach (prog[i]) begin
            apb_xfer(1'b1, 12'(4 * i), prog[i], unused);
        end
        apb_xfer(1'b1, 12'(4 * prog.size()), 32'h0, unused); // opcode 0 halts the core
        apb_xfer(1'b1, 12'h100, 32'h1, unused);              // run_start
    endtask

    task automatic finish_run();
        logic [31:0] st;
        do begin
            apb_xfer(1'b0, 12'h104, 32'h0, st);
        end while (!st[1]);
        check_read(12'h104, 32'h2); // halted, not busy
        pc_count: assert (DUT.pc == 32'(4 * prog.size()))
            else report_mismatch("pc", DUT.pc, 4 * prog.size());
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i++) begin
            check_read(12'h200 + 12'(8 * i), model_regs[i][31:0]);
            check_read(12'h204 + 12'(8 * i), model_regs[i][63:32]);
        end
    endtask

    initial begin
        logic [63:0] r;
        logic [31:0] unused;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        chk_rdata = 1'b0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        rng_state = 64'd27596;
        rd_count  = 0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // R-type on two random 64-bit values, both operand orders
        build_value(5'd1);
        build_value(5'd2);
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 10; i++) begin
                emit(rtype((i == 1 || i == 7) ? 7'h20 : 7'h00, s ? 5'd1 : 5'd2,
                           s ? 5'd2 : 5'd1, 3'(r_f3[i]), next_rd(), 7'h33));
            end
        end
        load_program();
        finish_run();
        check_regs();

        // I-type, word forms and auipc, all reading only x1 and x2
        prog.delete();
        for (int s = 1; s <= 2; s++) begin
            for (int i = 0; i < 6; i++) begin
                r = rand64();
                emit(itype(r[11:0], 5'(s), 3'(i_f3[i]), next_rd(), 7'h13));
            end
            r = rand64();
            emit(itype({6'b000000, r[5:0]}, 5'(s), 3'b001, next_rd(), 7'h13)); // slli
            emit(itype({6'b000000, r[11:6]}, 5'(s), 3'b101, next_rd(), 7'h13)); // srli
            emit(itype({6'b010000, r[17:12]}, 5'(s), 3'b101, next_rd(), 7'h13)); // srai
        end
        emit(itype(12'h800, 5'd1, 3'b000, next_rd(), 7'h13)); // addi -2048
        emit(itype(12'hff0, 5'd2, 3'b111, next_rd(), 7'h13)); // andi -16
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b000, next_rd(), 7'h3b)); // addw
        emit(rtype(7'h20, 5'd2, 5'd1, 3'b000, next_rd(), 7'h3b)); // subw
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b001, next_rd(), 7'h3b)); // sllw
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b101, next_rd(), 7'h3b)); // srlw
        emit(rtype(7'h20, 5'd2, 5'd1, 3'b101, next_rd(), 7'h3b)); // sraw
        r = rand64();
        emit(itype(r[11:0], 5'd2, 3'b000, next_rd(), 7'h1b));           // addiw
        emit(itype({7'b0, r[16:12]}, 5'd1, 3'b001, next_rd(), 7'h1b)); // slliw
        emit(utype(r[39:20], next_rd(), 7'h17));                        // auipc
        emit(utype(r[59:40], next_rd(), 7'h17));
        emit(utype(r[19:0], 5'd0, 7'h17));                   // auipc into x0
        emit(itype(12'd5, 5'd1, 3'b000, 5'd0, 7'h13));       // addi into x0
        load_program();
        finish_run();
        check_regs();

        // APB error responses
        expect_err(1'b1, 12'h104, 32'h3);  // status is read-only
        expect_err(1'b1, 12'h208, 32'h1);  // register window is read-only
        expect_err(1'b0, 12'h300, 32'h0);  // unmapped read
        expect_err(1'b1, 12'h10c, 32'h0);  // unmapped write

        // rerun the same program and poke the memory while it runs
        apb_xfer(1'b1, 12'h100, 32'h1, unused);
        check_read(12'h104, 32'h1);        // busy, not halted
        expect_err(1'b1, 12'h000, 32'hffff_ffff);
        finish_run();
        check_regs();
        check_read(12'h000, prog[0]);      // word 0 kept its instruction

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: filelist.f
rtl/core_pkg.sv
rtl/opdecoder.sv
rtl/fsm_alu.sv
rtl/alu.sv
rtl/regfile.sv
rtl/datapath.sv
rtl/apb_host_port.sv
rtl/alu_core_top.sv
testbench/tb_alu_core.sv
